// File: Makefile
# Verilator build and run for the coherence engine testbench

VERILATOR ?= verilator
TOP       ?= cce_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/cce_execute.sv
// Execute stage with register file, adder, branch resolution and stall detection
module cce_execute
  import cce_pkg::*;
  import cce_isa_pkg::*;
 (input              clk_i
  , input            arst_n_i
  , input opcode_e   op_i
  , input gpr_sel_t  dst_i
  , input gpr_sel_t  src_i
  , input gpr_t      imm_i
  , input            v_i

  , input            pending_i
  , input addr_t     req_addr_i
  , input            req_avail_i
  , input            cmd_avail_i

  , output logic     stall_o
  , output logic     mispredict_o
  , output pc_t      branch_pc_o

  , output logic     pend_set_o
  , output logic     pend_clr_o
  , output addr_t    pend_addr_o

  , output logic     pop_o
  , output logic     send_o
  , output gpr_t     send_addr_o
  , output gpr_t     send_data_o
 );

  gpr_t gpr_r [num_gpr_lp];
  gpr_t src_val;
  gpr_t dst_val;
  gpr_t wr_data;
  logic wr_en;
  logic fire;

  assign src_val = gpr_r[src_i];
  assign dst_val = gpr_r[dst_i];

  // Hold the pipe until the port can take the transfer
  assign stall_o = v_i & (((op_i == op_popq) & ~req_avail_i)
                        | ((op_i == op_send) & ~cmd_avail_i));
  assign fire = v_i & ~stall_o;

  // Fetch always predicts not-taken
  assign mispredict_o = v_i & (op_i == op_bnz) & (src_val != '0);
  assign branch_pc_o  = imm_i[$bits(pc_t)-1:0];

  always_comb begin
    wr_en   = 1'b0;
    wr_data = dst_val;
    case (op_i)
      op_movi: begin
        wr_en   = fire;
        wr_data = imm_i;
      end
      op_add: begin
        wr_en   = fire;
        wr_data = dst_val + src_val;
      end
      op_prd: begin
        wr_en   = fire;
        wr_data = gpr_t'(pending_i);
      end
      op_popq: begin
        wr_en   = fire;
        wr_data = req_addr_i;
      end
      default: wr_en = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (~arst_n_i) begin
      for (int i = 0; i < num_gpr_lp; i++) begin
        gpr_r[i] <= '0;
      end
    end else if (wr_en) begin
      gpr_r[dst_i] <= wr_data;
    end
  end

  // Pending table is read and written through the src register
  assign pend_addr_o = src_val;
  assign pend_set_o  = fire & (op_i == op_pset);
  assign pend_clr_o  = fire & (op_i == op_pclr);

  assign pop_o       = v_i & (op_i == op_popq);
  assign send_o      = v_i & (op_i == op_send);
  assign send_addr_o = src_val;
  assign send_data_o = dst_val;

  a_pend_one_op: assert property (@(posedge clk_i) disable iff (~arst_n_i)
    !(pend_set_o && pend_clr_o));

endmodule

// File: hw/cce_inst_decode.sv
// Decode register that splits microcode fields, holds on stall, flushes on mispredict
module cce_inst_decode
  import cce_pkg::*;
  import cce_isa_pkg::*;
 (input              clk_i
  , input            arst_n_i
  , input instr_t    fetch_inst_i
  , input pc_t       fetch_pc_i
  , input            fetch_v_i
  , input            stall_i
  , input            mispredict_i
  , output opcode_e  op_o
  , output gpr_sel_t dst_o
  , output gpr_sel_t src_o
  , output gpr_t     imm_o
  , output pc_t      pc_o
  , output logic     v_o
 );

  logic [3:0] raw_op;
  opcode_e    op_d;

  assign raw_op = fetch_inst_i[opcode_lsb_lp +: 4];
  // Undefined codes fall back to nop
  assign op_d = (raw_op <= op_send) ? opcode_e'(raw_op) : op_nop;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (~arst_n_i) begin
      v_o <= 1'b0;
    end else if (mispredict_i) begin
      v_o <= 1'b0;
    end else if (~stall_i) begin
      v_o <= fetch_v_i;
    end
  end

  // Payload fields
  always_ff @(posedge clk_i) begin
    if (~stall_i) begin
      op_o  <= op_d;
      dst_o <= fetch_inst_i[dst_lsb_lp +: $bits(gpr_sel_t)];
      src_o <= fetch_inst_i[src_lsb_lp +: $bits(gpr_sel_t)];
      imm_o <= gpr_t'(fetch_inst_i[imm_width_lp-1:0]);
      pc_o  <= fetch_pc_i;
    end
  end

  // A redirect also drops the fetched word, so decode stays empty for two cycles
  a_flush_two_bubbles: assert property (@(posedge clk_i) disable iff (~arst_n_i)
    mispredict_i |=> !v_o ##1 !v_o);

endmodule

// File: hw/cce_inst_ram.sv
// Microcode RAM with programming port and the fetch program counter
module cce_inst_ram
  import cce_pkg::*;
  import cce_isa_pkg::*;
 (input            clk_i
  , input          arst_n_i
  , input          run_i

  // Programming port, synchronous read
  , input          ucode_v_i
  , input          ucode_w_i
  , input pc_t     ucode_addr_i
  , input instr_t  ucode_data_i
  , output instr_t ucode_data_o

  // Redirect and hold from execute
  , input          stall_i
  , input          mispredict_i
  , input pc_t     branch_pc_i

  , output instr_t fetch_inst_o
  , output pc_t    fetch_pc_o
  , output logic   fetch_v_o
 );

  instr_t mem [num_instr_lp];
  instr_t rdata_r;
  pc_t    pc_r;
  pc_t    fetch_pc_r;
  logic   fetch_v_r;
  pc_t    rd_addr;
  logic   rd_en;

  // Programming port owns the RAM while the engine is not running
  assign rd_addr = run_i ? pc_r : ucode_addr_i;
  assign rd_en   = run_i ? ~stall_i : (ucode_v_i & ~ucode_w_i);

  always_ff @(posedge clk_i) begin
    if (~run_i & ucode_v_i & ucode_w_i) begin
      mem[ucode_addr_i] <= ucode_data_i;
    end
    // Output word held during a stall
    if (rd_en) begin
      rdata_r <= mem[rd_addr];
    end
  end

  // pc_r is the address in flight, fetch_pc_r the word on the output
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (~arst_n_i) begin
      pc_r       <= '0;
      fetch_pc_r <= '0;
      fetch_v_r  <= 1'b0;
    end else if (~run_i) begin
      pc_r      <= '0;
      fetch_v_r <= 1'b0;
    end else if (mispredict_i) begin
      // Word read this cycle is on the wrong path
      pc_r      <= branch_pc_i;
      fetch_v_r <= 1'b0;
    end else if (~stall_i) begin
      pc_r       <= pc_r + 1'b1;
      fetch_pc_r <= pc_r;
      fetch_v_r  <= 1'b1;
    end
  end

  assign ucode_data_o = rdata_r;
  assign fetch_inst_o = rdata_r;
  assign fetch_pc_o   = fetch_pc_r;
  assign fetch_v_o    = fetch_v_r;

endmodule

// File: hw/cce_isa_pkg.sv
// Microcode opcode encoding and instruction field layout
package cce_isa_pkg;

  // Layout, from the top: opcode, dst, src, imm
  localparam int instr_width_lp  = 16;
  localparam int imm_width_lp    = 8;
  localparam int src_lsb_lp      = imm_width_lp;
  localparam int dst_lsb_lp      = src_lsb_lp + 2;
  localparam int opcode_lsb_lp   = dst_lsb_lp + 2;

  typedef logic [instr_width_lp-1:0] instr_t;

  // Codes above op_send are treated as nop by decode
  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_movi  = 4'd1,
    op_add   = 4'd2,
    op_bnz   = 4'd3,
    op_popq  = 4'd4,
    op_prd   = 4'd5,
    op_pset  = 4'd6,
    op_pclr  = 4'd7,
    op_send  = 4'd8
  } opcode_e;

endpackage

// File: hw/cce_msg.sv
// LCE request pop and memory command send for the execute stage
module cce_msg
  import cce_pkg::*;
 (input           clk_i
  , input         arst_n_i

  // From execute
  , input         pop_i
  , input         send_i
  , input gpr_t   send_addr_i
  , input gpr_t   send_data_i

  // LCE request queue, valid/yumi
  , input addr_t  lce_req_addr_i
  , input         lce_req_v_i
  , output logic  lce_req_yumi_o

  // Memory command, ready-then-valid
  , input         mem_cmd_ready_i
  , output addr_t mem_cmd_addr_o
  , output gpr_t  mem_cmd_data_o
  , output logic  mem_cmd_v_o

  // Back to execute
  , output addr_t req_addr_o
  , output logic  req_avail_o
  , output logic  cmd_avail_o
 );

  assign req_avail_o = lce_req_v_i;
  assign cmd_avail_o = mem_cmd_ready_i;
  assign req_addr_o  = lce_req_addr_i;

  // Request consumed on the edge where yumi is high
  assign lce_req_yumi_o = pop_i & lce_req_v_i;

  // Valid only raised once ready is already seen
  assign mem_cmd_v_o    = send_i & mem_cmd_ready_i;
  assign mem_cmd_addr_o = send_addr_i;
  assign mem_cmd_data_o = send_data_i;

  a_cmd_ready: assert property (@(posedge clk_i) disable iff (~arst_n_i)
    mem_cmd_v_o |-> mem_cmd_ready_i);

  a_yumi_valid: assert property (@(posedge clk_i) disable iff (~arst_n_i)
    lce_req_yumi_o |-> lce_req_v_i);

endmodule

// File: hw/cce_pending_bits.sv
// Pending flags indexed by way group, combinational read and clocked set/clear
module cce_pending_bits
  import cce_pkg::*;
 (input          clk_i
  , input        arst_n_i
  , input        set_i
  , input        clr_i
  , input addr_t addr_i
  , output logic pending_o
 );

  logic [num_way_groups_lp-1:0] flags_r;
  way_group_t                   wg;

  // Block offset dropped, next bits pick the group
  assign wg = addr_i[block_offset_lp +: $bits(way_group_t)];

  assign pending_o = flags_r[wg];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (~arst_n_i) begin
      flags_r <= '0;
    end else if (set_i) begin
      flags_r[wg] <= 1'b1;
    end else if (clr_i) begin
      flags_r[wg] <= 1'b0;
    end
  end

endmodule

// File: hw/cce_pkg.sv
// Engine widths, vector types and table sizes
package cce_pkg;

  // Microcode store
  localparam int pc_width_lp   = 6;
  localparam int num_instr_lp  = 2 ** pc_width_lp;

  // Datapath
  localparam int gpr_width_lp  = 16;
  localparam int num_gpr_lp    = 4;
  localparam int gpr_sel_width_lp = $clog2(num_gpr_lp);

  // Pending table, one flag per way group
  localparam int num_way_groups_lp = 16;
  localparam int way_group_width_lp = $clog2(num_way_groups_lp);

  // 64 byte blocks, so the way group starts at address bit 6
  localparam int block_offset_lp = 6;

  typedef logic [pc_width_lp-1:0]        pc_t;
  typedef logic [gpr_width_lp-1:0]       gpr_t;
  // Addresses travel in registers, so they share the register width
  typedef logic [gpr_width_lp-1:0]       addr_t;
  typedef logic [gpr_sel_width_lp-1:0]   gpr_sel_t;
  typedef logic [way_group_width_lp-1:0] way_group_t;

endpackage

// File: hw/cce_top.sv
// Coherence engine top connecting fetch, decode, execute, pending bits and messages
module cce_top
  import cce_pkg::*;
  import cce_isa_pkg::*;
 (input            clk_i
  , input          arst_n_i
  , input          run_i

  , input          ucode_v_i
  , input          ucode_w_i
  , input pc_t     ucode_addr_i
  , input instr_t  ucode_data_i
  , output instr_t ucode_data_o

  , input addr_t   lce_req_addr_i
  , input          lce_req_v_i
  , output logic   lce_req_yumi_o

  , output addr_t  mem_cmd_addr_o
  , output gpr_t   mem_cmd_data_o
  , output logic   mem_cmd_v_o
  , input          mem_cmd_ready_i
 );

  // Fetch to decode
  instr_t   fetch_inst;
  pc_t      fetch_pc;
  logic     fetch_v;

  // Decode to execute
  opcode_e  dec_op;
  gpr_sel_t dec_dst;
  gpr_sel_t dec_src;
  gpr_t     dec_imm;
  logic     dec_v;

  // Execute back to the front end
  logic     stall;
  logic     mispredict;
  pc_t      branch_pc;

  // Execute to pending bits and messages
  logic     pend_set;
  logic     pend_clr;
  addr_t    pend_addr;
  logic     pending;
  logic     pop;
  logic     send;
  gpr_t     send_addr;
  gpr_t     send_data;
  addr_t    req_addr;
  logic     req_avail;
  logic     cmd_avail;

  cce_inst_ram u_inst_ram
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.run_i(run_i)
    ,.ucode_v_i(ucode_v_i)
    ,.ucode_w_i(ucode_w_i)
    ,.ucode_addr_i(ucode_addr_i)
    ,.ucode_data_i(ucode_data_i)
    ,.ucode_data_o(ucode_data_o)
    ,.stall_i(stall)
    ,.mispredict_i(mispredict)
    ,.branch_pc_i(branch_pc)
    ,.fetch_inst_o(fetch_inst)
    ,.fetch_pc_o(fetch_pc)
    ,.fetch_v_o(fetch_v)
    );

  // Execute resolves branches from imm alone, so the decoded pc stays a trace tap
  cce_inst_decode u_inst_decode
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.fetch_inst_i(fetch_inst)
    ,.fetch_pc_i(fetch_pc)
    ,.fetch_v_i(fetch_v)
    ,.stall_i(stall)
    ,.mispredict_i(mispredict)
    ,.op_o(dec_op)
    ,.dst_o(dec_dst)
    ,.src_o(dec_src)
    ,.imm_o(dec_imm)
    ,.pc_o()
    ,.v_o(dec_v)
    );

  cce_execute u_execute
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.op_i(dec_op)
    ,.dst_i(dec_dst)
    ,.src_i(dec_src)
    ,.imm_i(dec_imm)
    ,.v_i(dec_v)
    ,.pending_i(pending)
    ,.req_addr_i(req_addr)
    ,.req_avail_i(req_avail)
    ,.cmd_avail_i(cmd_avail)
    ,.stall_o(stall)
    ,.mispredict_o(mispredict)
    ,.branch_pc_o(branch_pc)
    ,.pend_set_o(pend_set)
    ,.pend_clr_o(pend_clr)
    ,.pend_addr_o(pend_addr)
    ,.pop_o(pop)
    ,.send_o(send)
    ,.send_addr_o(send_addr)
    ,.send_data_o(send_data)
    );

  cce_pending_bits u_pending_bits
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.set_i(pend_set)
    ,.clr_i(pend_clr)
    ,.addr_i(pend_addr)
    ,.pending_o(pending)
    );

  cce_msg u_msg
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.pop_i(pop)
    ,.send_i(send)
    ,.send_addr_i(send_addr)
    ,.send_data_i(send_data)
    ,.lce_req_addr_i(lce_req_addr_i)
    ,.lce_req_v_i(lce_req_v_i)
    ,.lce_req_yumi_o(lce_req_yumi_o)
    ,.mem_cmd_ready_i(mem_cmd_ready_i)
    ,.mem_cmd_addr_o(mem_cmd_addr_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.req_addr_o(req_addr)
    ,.req_avail_o(req_avail)
    ,.cmd_avail_o(cmd_avail)
    );

endmodule

// File: tb/cce_tb.sv
// Testbench for the coherence engine with program table, request table, model and checks
module cce_tb
  import cce_pkg::*;
  import cce_isa_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_half_lp     = 10;
  localparam int reset_cycles_lp = 16;
  localparam int prog_len_lp     = 13;
  localparam int num_req_lp      = 12;
  localparam int tail_cycles_lp  = 40;
  // Reset, up to three cycles per program word, 200 cycles per request, quiet tail
  localparam int watchdog_cycles_lp = reset_cycles_lp + 3 * prog_len_lp
                                    + 200 * num_req_lp + 2 * tail_cycles_lp;

  logic   clk_i;
  logic   arst_n_i;
  logic   run_i;
  logic   ucode_v_i;
  logic   ucode_w_i;
  pc_t    ucode_addr_i;
  instr_t ucode_data_i;
  instr_t ucode_data_o;
  addr_t  lce_req_addr_i;
  logic   lce_req_v_i;
  logic   lce_req_yumi_o;
  addr_t  mem_cmd_addr_o;
  gpr_t   mem_cmd_data_o;
  logic   mem_cmd_v_o;
  logic   mem_cmd_ready_i;

  instr_t      prog_tbl [prog_len_lp];
  addr_t       req_tbl  [num_req_lp];
  gpr_t        exp_data [num_req_lp];
  logic [15:0] lfsr_q;

  cce_top u_cce_top
   (.clk_i(clk_i)
    ,.arst_n_i(arst_n_i)
    ,.run_i(run_i)
    ,.ucode_v_i(ucode_v_i)
    ,.ucode_w_i(ucode_w_i)
    ,.ucode_addr_i(ucode_addr_i)
    ,.ucode_data_i(ucode_data_i)
    ,.ucode_data_o(ucode_data_o)
    ,.lce_req_addr_i(lce_req_addr_i)
    ,.lce_req_v_i(lce_req_v_i)
    ,.lce_req_yumi_o(lce_req_yumi_o)
    ,.mem_cmd_addr_o(mem_cmd_addr_o)
    ,.mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_v_o(mem_cmd_v_o)
    ,.mem_cmd_ready_i(mem_cmd_ready_i)
    );

  initial clk_i = 1'b0;
  always #clk_half_lp clk_i = ~clk_i;

  // Instruction word: opcode, dst, src, imm from the top down
  function automatic instr_t encode(opcode_e op, gpr_sel_t dst, gpr_sel_t src, logic [7:0] imm);
    return {op, dst, src, imm};
  endfunction

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      val    = {val[30:0], lfsr_q[15]};
      lfsr_q = {lfsr_q[14:0], fb};
    end
    return val;
  endfunction

  task automatic fail_value(string name, logic [15:0] got, logic [15:0] exp);
    $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic fail_note(string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic load_tables();
    prog_tbl[0]  = encode(op_movi, 2'd3, 2'd0, 8'h01);
    // Loop entry at word 1
    prog_tbl[1]  = encode(op_popq, 2'd0, 2'd0, 8'h00);
    prog_tbl[2]  = encode(op_prd,  2'd1, 2'd0, 8'h00);
    prog_tbl[3]  = encode(op_bnz,  2'd0, 2'd1, 8'h08);
    prog_tbl[4]  = encode(op_pset, 2'd0, 2'd0, 8'h00);
    prog_tbl[5]  = encode(op_movi, 2'd2, 2'd0, 8'h10);
    prog_tbl[6]  = encode(op_send, 2'd2, 2'd0, 8'h00);
    prog_tbl[7]  = encode(op_bnz,  2'd0, 2'd3, 8'h01);
    // Busy path at word 8
    prog_tbl[8]  = encode(op_pclr, 2'd0, 2'd0, 8'h00);
    prog_tbl[9]  = encode(op_movi, 2'd2, 2'd0, 8'h20);
    prog_tbl[10] = encode(op_add,  2'd2, 2'd3, 8'h00);
    prog_tbl[11] = encode(op_send, 2'd2, 2'd0, 8'h00);
    prog_tbl[12] = encode(op_bnz,  2'd0, 2'd3, 8'h01);
    // Groups 1, 2, 15 and 0 are hit more than once, high bits outside the index vary
    req_tbl[0]  = 16'h0040;
    req_tbl[1]  = 16'h0080;
    req_tbl[2]  = 16'h0044;
    req_tbl[3]  = 16'h1040;
    req_tbl[4]  = 16'h03C0;
    req_tbl[5]  = 16'h0090;
    req_tbl[6]  = 16'h2080;
    req_tbl[7]  = 16'h03FF;
    req_tbl[8]  = 16'h0000;
    req_tbl[9]  = 16'h0400;
    req_tbl[10] = 16'h0100;
    req_tbl[11] = 16'h8044;
  endtask

  // Reference model of the flags, one prediction per request
  task automatic build_model();
    logic [num_way_groups_lp-1:0] busy;
    addr_t                        line;
    int                           wg;
    busy = '0;
    for (int i = 0; i < num_req_lp; i++) begin
      line = req_tbl[i] >> block_offset_lp;
      wg   = int'(line) % num_way_groups_lp;
      if (busy[wg]) begin
        exp_data[i] = 16'h0021;
        busy[wg]    = 1'b0;
      end else begin
        exp_data[i] = 16'h0010;
        busy[wg]    = 1'b1;
      end
    end
  endtask

  task automatic check_idle();
    assert (!lce_req_yumi_o) else fail_note("lce_req_yumi_o went high before run_i rose");
    assert (!mem_cmd_v_o) else fail_note("mem_cmd_v_o went high before run_i rose");
  endtask

  task automatic check_cmd(int idx);
    assert (mem_cmd_addr_o == req_tbl[idx])
      else fail_value("mem_cmd_addr_o", mem_cmd_addr_o, req_tbl[idx]);
    assert (mem_cmd_data_o == exp_data[idx])
      else fail_value("mem_cmd_data_o", mem_cmd_data_o, exp_data[idx]);
  endtask

  initial begin
    int   req_idx;
    int   cmd_idx;
    logic taken;
    arst_n_i        = 1'b0;
    run_i           = 1'b0;
    ucode_v_i       = 1'b0;
    ucode_w_i       = 1'b0;
    ucode_addr_i    = '0;
    ucode_data_i    = '0;
    lce_req_addr_i  = '0;
    lce_req_v_i     = 1'b0;
    mem_cmd_ready_i = 1'b0;
    lfsr_q          = 16'd25;
    req_idx         = 0;
    cmd_idx         = 0;
    load_tables();
    build_model();

    repeat (reset_cycles_lp) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // Program load, engine stopped
    for (int i = 0; i < prog_len_lp; i++) begin
      @(posedge clk_i);
      ucode_v_i    <= 1'b1;
      ucode_w_i    <= 1'b1;
      ucode_addr_i <= pc_t'(i);
      ucode_data_i <= prog_tbl[i];
      @(negedge clk_i);
      check_idle();
    end

    // Read back, word shows one cycle after the request
    for (int i = 0; i < prog_len_lp; i++) begin
      @(posedge clk_i);
      ucode_v_i    <= 1'b1;
      ucode_w_i    <= 1'b0;
      ucode_addr_i <= pc_t'(i);
      @(posedge clk_i);
      ucode_v_i <= 1'b0;
      @(negedge clk_i);
      check_idle();
      assert (ucode_data_o == prog_tbl[i])
        else fail_value("ucode_data_o", ucode_data_o, prog_tbl[i]);
    end

    @(posedge clk_i);
    run_i <= 1'b1;

    // Monitor on the falling edge, drive on the rising edge
    while (cmd_idx < num_req_lp) begin
      @(negedge clk_i);
      assert (!(mem_cmd_v_o && !mem_cmd_ready_i))
        else fail_note("mem_cmd_v_o was high while mem_cmd_ready_i was low");
      assert (!(lce_req_yumi_o && !lce_req_v_i))
        else fail_note("lce_req_yumi_o was high while lce_req_v_i was low");
      taken = lce_req_yumi_o;
      if (mem_cmd_v_o) begin
        check_cmd(cmd_idx);
        cmd_idx++;
      end
      @(posedge clk_i);
      if (taken) begin
        req_idx++;
      end
      mem_cmd_ready_i <= (rand_bits(2) != 0);
      // A presented request stays up until it is taken
      if (lce_req_v_i && !taken) begin
        lce_req_v_i <= 1'b1;
      end else if (req_idx < num_req_lp && rand_bits(1) == 1) begin
        lce_req_v_i    <= 1'b1;
        lce_req_addr_i <= req_tbl[req_idx];
      end else begin
        lce_req_v_i <= 1'b0;
      end
    end

    // Quiet tail, no extra or repeated command
    mem_cmd_ready_i <= 1'b1;
    lce_req_v_i     <= 1'b0;
    repeat (tail_cycles_lp) begin
      @(negedge clk_i);
      assert (!mem_cmd_v_o) else fail_note("A memory command was sent after the last request");
      assert (!lce_req_yumi_o) else fail_note("lce_req_yumi_o rose with no request left");
    end
    assert (req_idx == num_req_lp)
      else fail_note($sformatf("Only %0d of %0d requests were consumed", req_idx, num_req_lp));

    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(watchdog_cycles_lp * 2 * clk_half_lp);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles_lp);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: verilog.f
hw/cce_pkg.sv
hw/cce_isa_pkg.sv
hw/cce_inst_ram.sv
hw/cce_inst_decode.sv
hw/cce_execute.sv
hw/cce_pending_bits.sv
hw/cce_msg.sv
hw/cce_top.sv
tb/cce_tb.sv
